// ==== flist.f ====
+incdir+hdl
hdl/exec_isa_pkg.sv
hdl/exec_bus_pkg.sv
hdl/exec_alu.sv
hdl/exec_branch.sv
hdl/exec_lsu.sv
hdl/exec_trap.sv
hdl/exec_writeback.sv
hdl/exec_stage.sv
bench/exec_stage_checker.sv
bench/exec_stage_tb.sv

// ==== Makefile ====
# Verilator build and run for the execute stage

VERILATOR ?= verilator
TOP       ?= exec_stage_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

PASS_MSG  := Test OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/exec_stage_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_stage_tb;

    import exec_isa_pkg::*;
    import exec_bus_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int N_ALU      = 300;
    localparam int N_BRANCH   = 200;
    localparam int N_MEM      = 200;
    localparam int N_STALL    = 40;
    // Bursts take up to 7 cycles, everything else one, doubled for margin
    localparam int TIMEOUT_CYCLES = 2 * (N_ALU + N_BRANCH + N_MEM + 8 * N_STALL) + 40;

    logic        clk;
    logic        reset_n;
    logic        stall;
    exec_in_t    ex;
    priv_e       priv;
    logic [31:0] mtvec;
    logic [31:0] mepc;
    logic        exc_illegal;
    logic        exc_fetch_fault;
    mem_req_t    mem_req;
    wb_t         wb;
    redirect_t   redirect;
    string       test_name;

    op_e alu_ops [13] = '{ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU, LUI, AUIPC, JAL};
    op_e br_ops  [7]  = '{BEQ, BNE, BLT, BGE, BLTU, BGEU, JALR};
    op_e mem_ops [8]  = '{LB, LBU, LH, LHU, LW, SB, SH, SW};

    exec_stage UUT (
        .clk(clk), .reset_n(reset_n), .stall_i(stall), .ex_i(ex), .priv_i(priv),
        .mtvec_i(mtvec), .mepc_i(mepc), .exc_illegal_i(exc_illegal),
        .exc_fetch_fault_i(exc_fetch_fault),
        .mem_req_o(mem_req), .wb_o(wb), .redirect_o(redirect)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Run timed out after %0d cycles without finishing", TIMEOUT_CYCLES);
        $display("Test FAILED");
        $fatal(1, "Timeout");
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] model_sum(exec_in_t e);
        return (e.op == SUB) ? e.rs1_data - e.second_operand : e.rs1_data + e.second_operand;
    endfunction

    function automatic logic model_taken(exec_in_t e);
        logic [31:0] a;
        logic [31:0] b;
        a = e.rs1_data;
        b = e.second_operand;
        case (e.op)
            BEQ:       return a == b;
            BNE:       return a != b;
            BLT:       return $signed(a) < $signed(b);
            BGE:       return $signed(a) >= $signed(b);
            BLTU:      return a < b;
            BGEU:      return a >= b;
            JAL, JALR: return 1'b1;
            default:   return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] model_target(exec_in_t e);
        return (e.op == JALR) ? (model_sum(e) & ~32'd1) : e.jump_imm_target;
    endfunction

    function automatic logic [31:0] model_result(exec_in_t e);
        logic [31:0] a;
        logic [31:0] b;
        a = e.rs1_data;
        b = e.second_operand;
        case (e.op)
            AND:       return a & b;
            OR:        return a | b;
            XOR:       return a ^ b;
            SLL:       return a << b[4:0];
            SRL:       return a >> b[4:0];
            SRA:       return $signed(a) >>> b[4:0];
            SLT:       return {31'd0, $signed(a) < $signed(b)};
            SLTU:      return {31'd0, a < b};
            LUI:       return b;
            AUIPC:     return e.jump_imm_target;
            JAL, JALR: return e.pc + 32'd4;
            default:   return model_sum(e);
        endcase
    endfunction

    // Highest priority cause first
    function automatic exc_code_e model_exc(exec_in_t e);
        logic [31:0] sum;
        logic [31:0] tgt;
        logic [1:0]  off;
        sum = model_sum(e);
        tgt = model_target(e);
        off = sum[1:0];  // Byte offset of the access
        if (exc_fetch_fault)                              return INSTRUCTION_ACCESS_FAULT;
        if (exc_illegal || (e.op == MRET && priv == USER)) return ILLEGAL_INSTRUCTION;
        if (model_taken(e) && tgt[1])                      return INSTRUCTION_ADDRESS_MISALIGNED;
        if (e.op == ECALL) return (priv == USER) ? ECALL_FROM_UMODE : ECALL_FROM_MMODE;
        if (e.op == EBREAK)                                return BREAKPOINT;
        if ((e.op inside {LH, LHU} && off[0]) || (e.op == LW && off != 2'd0))
            return LOAD_ADDRESS_MISALIGNED;
        if ((e.op == SH && off[0]) || (e.op == SW && off != 2'd0))
            return STORE_AMO_ADDRESS_MISALIGNED;
        return NE;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Checking and stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (exp === act) else begin
            $display("ERROR %s %s expected %h actual %h", test_name, what, exp, act);
            $display("Test FAILED");
            $fatal(1, "Mismatch");
        end
    endtask

    function automatic exec_in_t make_op(op_e op, logic [31:0] a, logic [31:0] b);
        exec_in_t e;
        e.op              = op;
        e.rs1_data        = a;
        e.rs2_data        = $urandom;
        e.second_operand  = b;
        e.rd              = ($urandom_range(0, 7) == 0) ? 5'd0 : 5'($urandom);
        e.pc              = $urandom & ~32'd3;
        e.jump_imm_target = $urandom & ~32'd3;
        e.valid           = 1'b1;
        return e;
    endfunction

    // Enter at edge + 1 ns, leave at the next edge + 1 ns
    task automatic run_op(input exec_in_t e, input logic jump_issued = 1'b0);
        exc_code_e   exp_exc;
        logic        exp_jump;
        logic        exp_ret;
        logic        exp_we;
        logic [31:0] addr;
        logic [3:0]  exp_strb;
        logic [31:0] exp_wdata;
        exp_exc  = model_exc(e);
        exp_jump = model_taken(e);
        exp_ret  = (e.op == MRET) && (priv == MACHINE) && (exp_exc == NE);
        exp_we   = !(e.op inside {NOP, SB, SH, SW, BEQ, BNE, BLT, BLTU, BGE, BGEU}) &&
                   (e.rd != 5'd0) && (exp_exc == NE);
        addr     = model_sum(e);
        case (e.op)
            SB:      exp_strb = 4'(4'b0001 << addr[1:0]);
            SH:      exp_strb = 4'(4'b0011 << addr[1:0]);
            SW:      exp_strb = 4'b1111;
            default: exp_strb = 4'b0000;
        endcase
        case (e.op)
            SB:      exp_wdata = {4{e.rs2_data[7:0]}};
            SH:      exp_wdata = {2{e.rs2_data[15:0]}};
            default: exp_wdata = e.rs2_data;
        endcase
        ex    = e;
        stall = 1'b0;
        #2;
        // Pulse already given during the stall episode
        check_value("jump", 32'(exp_jump && !jump_issued), 32'(redirect.jump));
        if (exp_jump)
            check_value("jump target", model_target(e), redirect.jump_target);
        check_value("exception code", 32'(exp_exc), 32'(redirect.exc_code));
        check_value("raise", 32'(exp_exc != NE), 32'(redirect.raise_exception));
        check_value("mret", 32'(exp_ret), 32'(redirect.machine_return));
        check_value("ctx switch", 32'(exp_ret || exp_exc != NE), 32'(redirect.ctx_switch));
        if (redirect.ctx_switch)
            check_value("ctx target", exp_ret ? mepc : mtvec, redirect.ctx_target);
        @(posedge clk);
        #1;
        check_value("write enable", 32'(exp_we), 32'(wb.we));
        check_value("wb op", 32'(e.op), 32'(wb.op));
        if (exp_we) begin
            check_value("result", model_result(e), wb.result);
            check_value("rd", 32'(e.rd), 32'(wb.rd));
        end
        check_value("read enable", 32'(e.op inside {LB, LBU, LH, LHU, LW}), 32'(mem_req.read_en));
        check_value("strobes", 32'(exp_strb), 32'(mem_req.strb));
        if (mem_req.read_en || exp_strb != 4'd0)
            check_value("address", addr, mem_req.addr);
        if (exp_strb != 4'd0)
            check_value("store data", exp_wdata, mem_req.wdata);
    endtask

    // Jump or MRET held under stall, then released
    task automatic stall_burst(input int cycles);
        exec_in_t e;
        wb_t      wb_snap;
        mem_req_t mem_snap;
        e = make_op(($urandom_range(0, 1) == 0) ? JAL : MRET, $urandom, $urandom);
        if ($urandom_range(0, 1) == 0)
            e.jump_imm_target = e.jump_imm_target | 32'd2;  // Misaligned jump traps
        wb_snap  = wb;
        mem_snap = mem_req;
        ex       = e;
        stall    = 1'b1;
        for (int i = 0; i < cycles; i++) begin
            #2;
            check_value("stall jump pulse", 32'((i == 0) && model_taken(e)), 32'(redirect.jump));
            check_value("stall ctx switch", 32'd0, 32'(redirect.ctx_switch));
            check_value("stall wb hold", 32'(wb_snap === wb), 32'd1);
            check_value("stall mem hold", 32'(mem_snap === mem_req), 32'd1);
            @(posedge clk);
            #1;
        end
        run_op(e, 1'b1);
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        exec_in_t    e;
        void'($urandom(27));
        reset_n         = 1'b0;
        stall           = 1'b0;
        ex              = '0;
        priv            = MACHINE;
        mtvec           = 32'h0000_0100;
        mepc            = 32'h0000_2468;
        exc_illegal     = 1'b0;
        exc_fetch_fault = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        reset_n = 1'b1;

        test_name = "alu";
        for (int i = 0; i < N_ALU; i++)
            run_op(make_op(alu_ops[$urandom_range(0, 12)], $urandom, $urandom));

        test_name = "branch";
        for (int i = 0; i < N_BRANCH; i++) begin
            a = $urandom;
            b = ($urandom_range(0, 2) == 0) ? a : $urandom;
            run_op(make_op(br_ops[$urandom_range(0, 6)], a, b));
        end

        test_name = "memory";
        for (int i = 0; i < N_MEM; i++) begin
            e    = make_op(mem_ops[$urandom_range(0, 7)], $urandom, 32'd0);
            addr = $urandom;
            if (e.op inside {LH, LHU, SH})
                addr = addr & ~32'd1;
            else if (e.op inside {LW, SW})
                addr = addr & ~32'd3;
            e.second_operand = addr - e.rs1_data;  // Aligned access address
            run_op(e);
        end

        test_name = "misaligned";
        for (int i = 0; i < 10; i++) begin
            a = $urandom;
            run_op(make_op(LH, a, (($urandom & ~32'd1) | 32'd1) - a));
            run_op(make_op(LW, a, (($urandom & ~32'd3) | 32'd2) - a));
            run_op(make_op(SH, a, (($urandom & ~32'd3) | 32'd3) - a));
            run_op(make_op(SW, a, (($urandom & ~32'd3) | 32'd1) - a));
            e = make_op(JAL, a, $urandom);
            e.jump_imm_target = e.jump_imm_target | 32'd2;
            run_op(e);
            run_op(make_op(JALR, a, (($urandom & ~32'd3) | 32'd3) - a));
        end

        test_name = "system";
        priv = USER;
        run_op(make_op(ECALL, $urandom, $urandom));
        run_op(make_op(MRET, $urandom, $urandom));  // Illegal outside machine mode
        priv = MACHINE;
        run_op(make_op(ECALL, $urandom, $urandom));
        run_op(make_op(EBREAK, $urandom, $urandom));
        run_op(make_op(MRET, $urandom, $urandom));
        exc_illegal = 1'b1;
        run_op(make_op(ADD, $urandom, $urandom));
        run_op(make_op(ECALL, $urandom, $urandom));
        exc_fetch_fault = 1'b1;
        run_op(make_op(ADD, $urandom, $urandom));
        exc_illegal = 1'b0;
        e = make_op(JAL, $urandom, $urandom);
        e.jump_imm_target = e.jump_imm_target | 32'd2;
        run_op(e);  // Fetch fault outranks misaligned target
        exc_fetch_fault = 1'b0;

        test_name = "stall";
        for (int i = 0; i < N_STALL; i++)
            stall_burst($urandom_range(2, 6));

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/exec_stage_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_stage_checker (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      stall_i,
    input  exec_bus_pkg::mem_req_t    mem_req_o,
    input  exec_bus_pkg::wb_t         wb_o,
    input  exec_bus_pkg::redirect_t   redirect_o
);

    import exec_isa_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Reset values
    ////////////////////////////////////////////////////////////////////////////

    a_reset_values: assert property (@(posedge clk)
        !reset_n |-> (!wb_o.we && (wb_o.op == NOP) &&
                      !mem_req_o.read_en && (mem_req_o.strb == '0)))
        else $error("Registered outputs not cleared by reset");

    ////////////////////////////////////////////////////////////////////////////
    // Stall behavior
    ////////////////////////////////////////////////////////////////////////////

    // Registers frozen across a stalled edge
    a_hold_on_stall: assert property (@(posedge clk) disable iff (!reset_n)
        stall_i |=> ($stable(wb_o) && $stable(mem_req_o)))
        else $error("Registered outputs changed while stalled");

    a_no_redirect_on_stall: assert property (@(posedge clk) disable iff (!reset_n)
        stall_i |-> (!redirect_o.ctx_switch && !redirect_o.raise_exception &&
                     !redirect_o.machine_return))
        else $error("Trap redirect raised while stalled");

    // One jump pulse per stall episode
    a_jump_one_shot: assert property (@(posedge clk) disable iff (!reset_n)
        (stall_i && redirect_o.jump) ##1 stall_i |-> !redirect_o.jump)
        else $error("Jump pulse repeated during one stall");

endmodule

bind exec_stage exec_stage_checker u_checker (
    .clk(clk),
    .reset_n(reset_n),
    .stall_i(stall_i),
    .mem_req_o(mem_req_o),
    .wb_o(wb_o),
    .redirect_o(redirect_o)
);

`default_nettype wire

// ==== hdl/exec_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_params.svh"

module exec_stage (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      stall_i,
    input  exec_bus_pkg::exec_in_t    ex_i,
    input  exec_isa_pkg::priv_e       priv_i,
    input  logic [`EXEC_XLEN-1:0]     mtvec_i,
    input  logic [`EXEC_XLEN-1:0]     mepc_i,
    input  logic                      exc_illegal_i,
    input  logic                      exc_fetch_fault_i,
    output exec_bus_pkg::mem_req_t    mem_req_o,
    output exec_bus_pkg::wb_t         wb_o,
    output exec_bus_pkg::redirect_t   redirect_o
);

    logic [`EXEC_XLEN-1:0] sum;
    logic [`EXEC_XLEN-1:0] result;
    logic                  eq;
    logic                  lt;
    logic                  ltu;
    logic                  should_jump;
    logic [`EXEC_XLEN-1:0] target;
    logic                  jump;
    logic                  load_misaligned;
    logic                  store_misaligned;
    logic                  raise_exception;

    exec_alu u_alu (
        .ex_i(ex_i), .sum_o(sum), .result_o(result), .eq_o(eq), .lt_o(lt), .ltu_o(ltu)
    );

    exec_branch u_branch (
        .clk(clk), .reset_n(reset_n), .stall_i(stall_i), .ex_i(ex_i),
        .sum_i(sum), .eq_i(eq), .lt_i(lt), .ltu_i(ltu),
        .should_jump_o(should_jump), .target_o(target), .jump_o(jump)
    );

    exec_lsu u_lsu (
        .clk(clk), .reset_n(reset_n), .stall_i(stall_i), .ex_i(ex_i), .sum_i(sum),
        .mem_req_o(mem_req_o),
        .load_misaligned_o(load_misaligned), .store_misaligned_o(store_misaligned)
    );

    // Jump pulse passes through the trap unit into the redirect bus
    exec_trap u_trap (
        .stall_i(stall_i), .ex_i(ex_i), .priv_i(priv_i),
        .mtvec_i(mtvec_i), .mepc_i(mepc_i),
        .exc_illegal_i(exc_illegal_i), .exc_fetch_fault_i(exc_fetch_fault_i),
        .should_jump_i(should_jump), .target_i(target), .jump_i(jump),
        .load_misaligned_i(load_misaligned), .store_misaligned_i(store_misaligned),
        .raise_exception_o(raise_exception), .redirect_o(redirect_o)
    );

    exec_writeback u_writeback (
        .clk(clk), .reset_n(reset_n), .stall_i(stall_i), .ex_i(ex_i),
        .result_i(result), .raise_exception_i(raise_exception), .wb_o(wb_o)
    );

endmodule

`default_nettype wire

// ==== hdl/exec_writeback.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_params.svh"

module exec_writeback (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     stall_i,
    input  exec_bus_pkg::exec_in_t   ex_i,
    input  logic [`EXEC_XLEN-1:0]    result_i,
    input  logic                     raise_exception_i,
    output exec_bus_pkg::wb_t        wb_o
);

    import exec_isa_pkg::*;

    logic                   we;
    logic                   no_dest;  // Op never writes a register
    logic                   we_q;
    op_e                    op_q;
    logic [`EXEC_REG_W-1:0] rd_q;
    logic [`EXEC_XLEN-1:0]  result_q;

    assign no_dest = ex_i.op inside {NOP, SB, SH, SW, BEQ, BNE, BLT, BLTU, BGE, BGEU};
    assign we      = ex_i.valid && !no_dest && (ex_i.rd != '0) && !raise_exception_i;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            we_q <= 1'b0;
            op_q <= NOP;
        end else if (!stall_i) begin
            we_q <= we;
            op_q <= ex_i.op;  // Memory stage picks load extension from this
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            rd_q     <= ex_i.rd;
            result_q <= result_i;
        end
    end

    assign wb_o.we     = we_q;
    assign wb_o.rd     = rd_q;
    assign wb_o.result = result_q;
    assign wb_o.op     = op_q;

endmodule

`default_nettype wire

// ==== hdl/exec_trap.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_params.svh"

module exec_trap (
    input  logic                      stall_i,
    input  exec_bus_pkg::exec_in_t    ex_i,
    input  exec_isa_pkg::priv_e       priv_i,
    input  logic [`EXEC_XLEN-1:0]     mtvec_i,
    input  logic [`EXEC_XLEN-1:0]     mepc_i,
    input  logic                      exc_illegal_i,
    input  logic                      exc_fetch_fault_i,
    input  logic                      should_jump_i,
    input  logic [`EXEC_XLEN-1:0]     target_i,
    input  logic                      jump_i,
    input  logic                      load_misaligned_i,
    input  logic                      store_misaligned_i,
    output logic                      raise_exception_o,  // Unmasked, for writeback
    output exec_bus_pkg::redirect_t   redirect_o
);

    import exec_isa_pkg::*;

    logic      is_mret;
    logic      illegal_mret;
    logic      iaddr_misaligned;
    logic      machine_return;
    exc_code_e exc_code;

    assign is_mret          = ex_i.valid && (ex_i.op == MRET);
    assign illegal_mret     = is_mret && (priv_i != MACHINE);
    assign iaddr_misaligned = should_jump_i && target_i[1];

    assign raise_exception_o = ex_i.valid && (
        exc_fetch_fault_i ||
        exc_illegal_i     ||
        illegal_mret      ||
        iaddr_misaligned  ||
        (ex_i.op inside {ECALL, EBREAK}) ||
        load_misaligned_i ||
        store_misaligned_i
    );

    // A faulting MRET traps instead of returning
    assign machine_return = is_mret && (priv_i == MACHINE) && !raise_exception_o;

    ////////////////////////////////////////////////////////////////////////////
    // Cause priority, highest first
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        if (!raise_exception_o)
            exc_code = NE;
        else if (exc_fetch_fault_i)
            exc_code = INSTRUCTION_ACCESS_FAULT;
        else if (exc_illegal_i || illegal_mret)
            exc_code = ILLEGAL_INSTRUCTION;
        else if (iaddr_misaligned)
            exc_code = INSTRUCTION_ADDRESS_MISALIGNED;
        else if (ex_i.op == ECALL)
            exc_code = (priv_i == USER) ? ECALL_FROM_UMODE : ECALL_FROM_MMODE;
        else if (ex_i.op == EBREAK)
            exc_code = BREAKPOINT;
        else if (load_misaligned_i)
            exc_code = LOAD_ADDRESS_MISALIGNED;
        else
            exc_code = STORE_AMO_ADDRESS_MISALIGNED;
    end

    // Privilege only changes once the instruction leaves the stage
    assign redirect_o.jump            = jump_i;
    assign redirect_o.jump_target     = target_i;
    assign redirect_o.raise_exception = raise_exception_o && !stall_i;
    assign redirect_o.machine_return  = machine_return && !stall_i;
    assign redirect_o.ctx_switch      = (raise_exception_o || machine_return) && !stall_i;
    assign redirect_o.ctx_target      = machine_return ? mepc_i : mtvec_i;
    assign redirect_o.exc_code        = exc_code;

endmodule

`default_nettype wire

// ==== hdl/exec_lsu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_params.svh"

module exec_lsu (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     stall_i,
    input  exec_bus_pkg::exec_in_t   ex_i,
    input  logic [`EXEC_XLEN-1:0]    sum_i,
    output exec_bus_pkg::mem_req_t   mem_req_o,
    output logic                     load_misaligned_o,
    output logic                     store_misaligned_o
);

    import exec_isa_pkg::*;

    localparam int OFF_W = $clog2(`EXEC_STRB_W);

    logic [OFF_W-1:0]        offset;  // Byte lane inside the word
    logic                    read_en;
    logic [`EXEC_STRB_W-1:0] strb;
    logic [`EXEC_XLEN-1:0]   wdata;

    logic                    read_en_q;
    logic [`EXEC_STRB_W-1:0] strb_q;
    logic [`EXEC_XLEN-1:0]   addr_q;
    logic [`EXEC_XLEN-1:0]   wdata_q;

    assign offset  = sum_i[OFF_W-1:0];
    assign read_en = ex_i.valid && (ex_i.op inside {LB, LBU, LH, LHU, LW});

    ////////////////////////////////////////////////////////////////////////////
    // Store lanes
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        strb  = '0;
        wdata = ex_i.rs2_data;
        unique case (ex_i.op)
            SB: begin
                strb  = {{(`EXEC_STRB_W-1){1'b0}}, 1'b1} << offset;
                wdata = {(`EXEC_STRB_W){ex_i.rs2_data[7:0]}};
            end
            SH: begin
                strb  = {{(`EXEC_STRB_W-2){1'b0}}, 2'b11} << offset;
                wdata = {(`EXEC_STRB_W/2){ex_i.rs2_data[15:0]}};
            end
            SW:      strb = '1;
            default: strb = '0;
        endcase
        if (!ex_i.valid) begin
            strb = '0;  // Bubble makes no access
        end
    end

    // Halfwords need an even address, words a multiple of four
    assign load_misaligned_o  = ((ex_i.op inside {LH, LHU}) && offset[0]) ||
                                ((ex_i.op == LW) && (offset != '0));
    assign store_misaligned_o = ((ex_i.op == SH) && offset[0]) ||
                                ((ex_i.op == SW) && (offset != '0));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            read_en_q <= 1'b0;
            strb_q    <= '0;
        end else if (!stall_i) begin
            read_en_q <= read_en;
            strb_q    <= strb;
        end
    end

    // Request address and store data
    always_ff @(posedge clk) begin
        if (!stall_i) begin
            addr_q  <= sum_i;
            wdata_q <= wdata;
        end
    end

    assign mem_req_o.addr    = addr_q;
    assign mem_req_o.read_en = read_en_q;
    assign mem_req_o.strb    = strb_q;
    assign mem_req_o.wdata   = wdata_q;

endmodule

`default_nettype wire

// ==== hdl/exec_branch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_params.svh"

module exec_branch (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     stall_i,
    input  exec_bus_pkg::exec_in_t   ex_i,
    input  logic [`EXEC_XLEN-1:0]    sum_i,
    input  logic                     eq_i,
    input  logic                     lt_i,
    input  logic                     ltu_i,
    output logic                     should_jump_o,
    output logic [`EXEC_XLEN-1:0]    target_o,
    output logic                     jump_o
);

    import exec_isa_pkg::*;

    logic taken;
    logic jump_seen;  // Jump already issued in this stall episode

    always_comb begin
        unique case (ex_i.op)
            BEQ:       taken = eq_i;
            BNE:       taken = !eq_i;
            BLT:       taken = lt_i;
            BGE:       taken = !lt_i;
            BLTU:      taken = ltu_i;
            BGEU:      taken = !ltu_i;
            JAL, JALR: taken = 1'b1;
            default:   taken = 1'b0;
        endcase
    end

    assign should_jump_o = ex_i.valid && taken;

    // JALR drops bit 0 of rs1 + imm
    assign target_o = (ex_i.op == JALR) ? {sum_i[`EXEC_XLEN-1:1], 1'b0}
                                        : ex_i.jump_imm_target;

    // Fetch reacts on the first cycle, so repeat pulses while stalled are masked
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            jump_seen <= 1'b0;
        end else if (!stall_i) begin
            jump_seen <= 1'b0;
        end else if (should_jump_o) begin
            jump_seen <= 1'b1;
        end
    end

    assign jump_o = should_jump_o && !jump_seen;

endmodule

`default_nettype wire

// ==== hdl/exec_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_params.svh"

module exec_alu (
    input  exec_bus_pkg::exec_in_t   ex_i,
    output logic [`EXEC_XLEN-1:0]    sum_o,
    output logic [`EXEC_XLEN-1:0]    result_o,
    output logic                     eq_o,
    output logic                     lt_o,
    output logic                     ltu_o
);

    import exec_isa_pkg::*;

    localparam int SHAMT_W = $clog2(`EXEC_XLEN);

    logic [`EXEC_XLEN-1:0] op_a;
    logic [`EXEC_XLEN-1:0] op_b;
    logic [`EXEC_XLEN-1:0] add_b;
    logic [SHAMT_W-1:0]    shamt;
    logic [`EXEC_XLEN-1:0] pc_next;

    assign op_a  = ex_i.rs1_data;
    assign op_b  = ex_i.second_operand;
    assign shamt = op_b[SHAMT_W-1:0];

    assign add_b = (ex_i.op == SUB) ? -op_b : op_b;  // Subtract by adding the negation
    assign sum_o = op_a + add_b;

    // Compares also feed the branch unit
    assign eq_o  = (op_a == op_b);
    assign lt_o  = ($signed(op_a) < $signed(op_b));
    assign ltu_o = (op_a < op_b);

    // Link address for JAL and JALR
    assign pc_next = ex_i.pc + `EXEC_INSN_BYTES;

    ////////////////////////////////////////////////////////////////////////////
    // Result select
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        unique case (ex_i.op)
            AND:       result_o = op_a & op_b;
            OR:        result_o = op_a | op_b;
            XOR:       result_o = op_a ^ op_b;
            SLL:       result_o = op_a << shamt;
            SRL:       result_o = op_a >> shamt;
            SRA:       result_o = $signed(op_a) >>> shamt;
            SLT:       result_o = {{(`EXEC_XLEN-1){1'b0}}, lt_o};
            SLTU:      result_o = {{(`EXEC_XLEN-1){1'b0}}, ltu_o};
            LUI:       result_o = op_b;                 // Upper immediate already shifted
            AUIPC:     result_o = ex_i.jump_imm_target;
            JAL, JALR: result_o = pc_next;
            default:   result_o = sum_o;                // ADD, SUB, address math
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/exec_bus_pkg.sv ====
`default_nettype none

`include "exec_params.svh"

package exec_bus_pkg;

    import exec_isa_pkg::*;

    // Decoded instruction entering the stage
    typedef struct packed {
        op_e                     op;
        logic [`EXEC_XLEN-1:0]   rs1_data;
        logic [`EXEC_XLEN-1:0]   rs2_data;
        logic [`EXEC_XLEN-1:0]   second_operand;  // rs2 or immediate
        logic [`EXEC_REG_W-1:0]  rd;
        logic [`EXEC_XLEN-1:0]   pc;
        logic [`EXEC_XLEN-1:0]   jump_imm_target; // pc + immediate
        logic                    valid;
    } exec_in_t;

    typedef struct packed {
        logic [`EXEC_XLEN-1:0]   addr;
        logic                    read_en;
        logic [`EXEC_STRB_W-1:0] strb;
        logic [`EXEC_XLEN-1:0]   wdata;
    } mem_req_t;

    typedef struct packed {
        logic                    we;
        logic [`EXEC_REG_W-1:0]  rd;
        logic [`EXEC_XLEN-1:0]   result;
        op_e                     op;
    } wb_t;

    // Fetch redirection and trap signalling
    typedef struct packed {
        logic                    jump;
        logic [`EXEC_XLEN-1:0]   jump_target;
        logic                    ctx_switch;
        logic [`EXEC_XLEN-1:0]   ctx_target;
        logic                    raise_exception;
        logic                    machine_return;
        exc_code_e               exc_code;
    } redirect_t;

endpackage

`default_nettype wire

// ==== hdl/exec_isa_pkg.sv ====
`default_nettype none

`include "exec_params.svh"

package exec_isa_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Operations handed over by decode
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [5:0] {
        NOP,
        ADD, SUB, AND, OR, XOR,
        SLL, SRL, SRA,
        SLT, SLTU,
        LUI, AUIPC,
        LB, LBU, LH, LHU, LW,
        SB, SH, SW,
        BEQ, BNE, BLT, BLTU, BGE, BGEU,
        JAL, JALR,
        ECALL, EBREAK, MRET
    } op_e;

    // Machine cause values, only the synchronous ones we can raise here
    typedef enum logic [3:0] {
        INSTRUCTION_ADDRESS_MISALIGNED = 4'd0,
        INSTRUCTION_ACCESS_FAULT       = 4'd1,
        ILLEGAL_INSTRUCTION            = 4'd2,
        BREAKPOINT                     = 4'd3,
        LOAD_ADDRESS_MISALIGNED        = 4'd4,
        STORE_AMO_ADDRESS_MISALIGNED   = 4'd6,
        ECALL_FROM_UMODE               = 4'd8,
        ECALL_FROM_MMODE               = 4'd11,
        NE                             = 4'd15  // No exception
    } exc_code_e;

    typedef enum logic [`EXEC_PRIV_W-1:0] {
        USER    = 2'b00,
        MACHINE = 2'b11
    } priv_e;

endpackage

`default_nettype wire

// ==== hdl/exec_params.svh ====
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// Datapath and address width
`define EXEC_XLEN        32

// Register file index
`define EXEC_REG_W       5

// One strobe bit per data byte
`define EXEC_STRB_W      4

// No compressed instructions so every step is a full word
`define EXEC_INSN_BYTES  4

`define EXEC_PRIV_W      2

`endif
